/* src/roce_gen_defs.svh */
`ifndef ROCE_GEN_DEFS_SVH
`define ROCE_GEN_DEFS_SVH

// transmit and descriptor stream geometry
`define AXIS_BYTES 64
`define AXIS_W 512
`define BEAT_IDX_W 3

// queue pairs
`define QP_COUNT 4
`define QP_IDX_W 2

// packets per phase
`define SEND_PKT_COUNT 8
`define READ_PKT_COUNT 8
`define WRITE_PKT_COUNT 8

// packet lengths in bytes
`define SEND_PAYLOAD_BYTES 80
`define READ_PAYLOAD_BYTES 256
`define ETH_HDR_BYTES 14
`define IPV4_HDR_BYTES 20
`define BTH_HDR_BYTES 54
`define AETH_HDR_BYTES 58
`define ICRC_BYTES 4
`define HDR_LEN_W 6
`define FRAME_LEN_W 9

// descriptor byte offsets, most significant byte first
`define WQE_QP_BYTE 47
`define WQE_PSN_BYTE 51

`endif

/* src/gen_ctrl_pkg.sv */
package gen_ctrl_pkg;

  // per queue pair destination and starting psn
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [31:0] dst_ip;
    logic [23:0] base_psn;
  } qp_ctx_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND,
    READ,
    WRITE,
    DONE
  } gen_phase_e;

endpackage

/* src/roce_hdr_pkg.sv */
package roce_hdr_pkg;

  // enum value is the BTH opcode
  typedef enum logic [7:0] {
    SEND      = 8'h04,
    READ_RESP = 8'h10,
    ACK       = 8'h11
  } frame_kind_e;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  typedef struct packed {
    logic [7:0]  ver_ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] ident;
    logic [15:0] flags_frag;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] checksum;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  flags;
    logic [15:0] pkey;
    logic [7:0]  rsvd0;
    logic [23:0] dst_qp;
    logic [7:0]  rsvd1;
    logic [23:0] psn;
  } bth_t;

  // first wire byte sits in the top bits
  typedef struct packed {
    eth_hdr_t    eth;
    ipv4_hdr_t   ipv4;
    udp_hdr_t    udp;
    bth_t        bth;
    logic [31:0] aeth;
  } roce_hdr_t;

endpackage

/* src/gen_ifs.sv */
`include "roce_gen_defs.svh"

// one-cycle header request, no back-pressure
interface hdr_req_if;
  logic                      req;
  roce_hdr_pkg::frame_kind_e kind;
  logic [23:0]               qp;
  logic [23:0]               psn;
  logic [7:0]                seq;

  modport master (output req, kind, qp, psn, seq);
  modport slave  (input  req, kind, qp, psn, seq);
endinterface

// built frame handed to the serializer, done comes back
interface frame_if;
  logic                           valid;
  logic [`AETH_HDR_BYTES*8-1:0]   hdr;
  logic [`HDR_LEN_W-1:0]          hdr_len;
  logic [`FRAME_LEN_W-1:0]        pay_len;
  logic [7:0]                     pay_byte;
  logic [`FRAME_LEN_W-1:0]        frame_len;
  logic                           done;

  modport master  (output valid, hdr, hdr_len, pay_len, pay_byte, frame_len);
  modport slave   (input  valid, hdr, hdr_len, pay_len, pay_byte, frame_len,
                   output done);
  modport monitor (input  done);
endinterface

/* src/qp_context_table.sv */
`include "roce_gen_defs.svh"

module qp_context_table (
  input  logic                  core_clk,
  input  logic                  core_aresetn,
  input  logic                  we_i,
  input  logic [`QP_IDX_W-1:0]  wr_idx_i,
  input  gen_ctrl_pkg::qp_ctx_t wr_ctx_i,
  input  logic [`QP_IDX_W-1:0]  rd_idx_i,
  output gen_ctrl_pkg::qp_ctx_t rd_ctx_o
);

  gen_ctrl_pkg::qp_ctx_t ctx_q [`QP_COUNT];

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      for (int i = 0; i < `QP_COUNT; i++) begin
        ctx_q[i] <= '0;
      end
    end else if (we_i) begin
      ctx_q[wr_idx_i] <= wr_ctx_i;
    end
  end

  // shared by sequencer and builder
  assign rd_ctx_o = ctx_q[rd_idx_i];

endmodule

/* src/pkt_sequencer.sv */
`include "roce_gen_defs.svh"

module pkt_sequencer (
  input  logic                 core_clk,
  input  logic                 core_aresetn,
  input  logic                 start_i,
  input  logic [`AXIS_W-1:0]   wqe_tdata_i,
  input  logic                 wqe_tvalid_i,
  hdr_req_if.master            req,
  frame_if.monitor             frame,
  input  logic [23:0]          rd_base_psn_i,
  output logic [`QP_IDX_W-1:0] rd_idx_o,
  output logic                 post_rd_wqe_o,
  output logic                 post_wr_wqe_o,
  output logic                 send_done_o,
  output logic                 read_done_o,
  output logic                 write_done_o
);

  typedef enum logic [1:0] {
    STEP_NEXT,
    STEP_WQE,
    STEP_REQ,
    STEP_BUSY
  } step_e;

  localparam logic [7:0] SEND_CNT  = `SEND_PKT_COUNT;
  localparam logic [7:0] READ_CNT  = `READ_PKT_COUNT;
  localparam logic [7:0] WRITE_CNT = `WRITE_PKT_COUNT;

  gen_ctrl_pkg::gen_phase_e phase_q;
  step_e                    step_q;
  logic [7:0]               cnt_q;
  logic [7:0]               phase_cnt;
  logic [23:0]              qp_q;
  logic [23:0]              psn_q;

  always_comb begin
    case (phase_q)
      gen_ctrl_pkg::SEND: phase_cnt = SEND_CNT;
      gen_ctrl_pkg::READ: phase_cnt = READ_CNT;
      default:            phase_cnt = WRITE_CNT;
    endcase
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      phase_q       <= gen_ctrl_pkg::IDLE;
      step_q        <= STEP_NEXT;
      cnt_q         <= '0;
      post_rd_wqe_o <= 1'b0;
      post_wr_wqe_o <= 1'b0;
      send_done_o   <= 1'b0;
      read_done_o   <= 1'b0;
      write_done_o  <= 1'b0;
    end else begin
      post_rd_wqe_o <= 1'b0;
      post_wr_wqe_o <= 1'b0;
      case (step_q)
        STEP_NEXT: begin
          if (phase_q == gen_ctrl_pkg::IDLE) begin
            if (start_i) begin
              phase_q <= gen_ctrl_pkg::SEND;
            end
          end else if (phase_q != gen_ctrl_pkg::DONE) begin
            if (cnt_q == phase_cnt) begin
              cnt_q <= '0;
              case (phase_q)
                gen_ctrl_pkg::SEND: begin
                  phase_q     <= gen_ctrl_pkg::READ;
                  send_done_o <= 1'b1;
                end
                gen_ctrl_pkg::READ: begin
                  phase_q     <= gen_ctrl_pkg::WRITE;
                  read_done_o <= 1'b1;
                end
                default: begin
                  phase_q      <= gen_ctrl_pkg::DONE;
                  write_done_o <= 1'b1;
                end
              endcase
            end else if (phase_q == gen_ctrl_pkg::SEND) begin
              step_q <= STEP_REQ;
            end else begin
              post_rd_wqe_o <= (phase_q == gen_ctrl_pkg::READ);
              post_wr_wqe_o <= (phase_q == gen_ctrl_pkg::WRITE);
              step_q        <= STEP_WQE;
            end
          end
        end
        STEP_WQE: begin
          if (wqe_tvalid_i) begin
            step_q <= STEP_REQ;
          end
        end
        STEP_REQ: step_q <= STEP_BUSY;
        default: begin
          if (frame.done) begin
            cnt_q  <= cnt_q + 8'd1;
            step_q <= STEP_NEXT;
          end
        end
      endcase
    end
  end

  // send packets rotate over the queue pairs, others take the descriptor
  always_ff @(posedge core_clk) begin
    if (step_q == STEP_NEXT) begin
      qp_q <= 24'(cnt_q[`QP_IDX_W-1:0]);
    end else if (step_q == STEP_WQE && wqe_tvalid_i) begin
      qp_q  <= {wqe_tdata_i[`WQE_QP_BYTE*8 +: 8],
                wqe_tdata_i[(`WQE_QP_BYTE+1)*8 +: 8],
                wqe_tdata_i[(`WQE_QP_BYTE+2)*8 +: 8]};
      psn_q <= {wqe_tdata_i[`WQE_PSN_BYTE*8 +: 8],
                wqe_tdata_i[(`WQE_PSN_BYTE+1)*8 +: 8],
                wqe_tdata_i[(`WQE_PSN_BYTE+2)*8 +: 8]};
    end
  end

  always_comb begin
    case (phase_q)
      gen_ctrl_pkg::SEND: req.kind = roce_hdr_pkg::SEND;
      gen_ctrl_pkg::READ: req.kind = roce_hdr_pkg::READ_RESP;
      default:            req.kind = roce_hdr_pkg::ACK;
    endcase
  end

  assign req.req  = (step_q == STEP_REQ);
  assign req.qp   = qp_q;
  assign req.seq  = cnt_q;
  assign req.psn  = (phase_q == gen_ctrl_pkg::SEND) ? rd_base_psn_i + 24'(cnt_q) : psn_q;
  assign rd_idx_o = qp_q[`QP_IDX_W-1:0];

endmodule

/* src/roce_hdr_builder.sv */
`include "roce_gen_defs.svh"

module roce_hdr_builder (
  input  logic                  core_clk,
  input  logic                  core_aresetn,
  hdr_req_if.slave              req,
  input  logic [47:0]           src_mac_i,
  input  logic [31:0]           src_ip_i,
  input  gen_ctrl_pkg::qp_ctx_t ctx_i,
  frame_if.master               frame
);

  localparam int LW = `FRAME_LEN_W;
  localparam logic [`HDR_LEN_W-1:0] SEND_HDR_LEN = `BTH_HDR_BYTES;
  localparam logic [`HDR_LEN_W-1:0] AETH_HDR_LEN = `AETH_HDR_BYTES;
  localparam logic [LW-1:0]         SEND_PAY_LEN = `SEND_PAYLOAD_BYTES;
  localparam logic [LW-1:0]         READ_PAY_LEN = `READ_PAYLOAD_BYTES;
  localparam logic [LW-1:0]         ICRC_LEN     = `ICRC_BYTES;

  roce_hdr_pkg::roce_hdr_t          hdr;
  logic [`AETH_HDR_BYTES*8-1:0]     hdr_swap;
  logic [`HDR_LEN_W-1:0]            hdr_len;
  logic [LW-1:0]                    pay_len;
  logic [LW-1:0]                    icrc_len;
  logic [7:0]                       pay_byte;
  logic [15:0]                      ip_len;

  // ones complement sum over ten words, carries folded twice
  function automatic logic [15:0] ip_csum(input roce_hdr_pkg::ipv4_hdr_t ip);
    logic [159:0] words;
    logic [19:0]  sum;
    words = ip;
    sum   = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + 20'(words[i*16 +: 16]);
    end
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    return ~sum[15:0];
  endfunction

  always_comb begin
    case (req.kind)
      roce_hdr_pkg::SEND: begin
        hdr_len  = SEND_HDR_LEN;
        pay_len  = SEND_PAY_LEN;
        icrc_len = '0;
        pay_byte = req.seq + 8'd1;
      end
      roce_hdr_pkg::READ_RESP: begin
        hdr_len  = AETH_HDR_LEN;
        pay_len  = READ_PAY_LEN;
        icrc_len = ICRC_LEN;
        pay_byte = {4'h1, req.seq[3:0] + 4'h1};
      end
      default: begin
        hdr_len  = AETH_HDR_LEN;
        pay_len  = '0;
        icrc_len = '0;
        pay_byte = 8'h00;
      end
    endcase
    // ip length always counts the icrc, wire or not
    ip_len = 16'(hdr_len) + 16'(pay_len) + 16'(`ICRC_BYTES) - 16'(`ETH_HDR_BYTES);

    hdr.eth  = '{dst_mac: ctx_i.dst_mac, src_mac: src_mac_i, ethertype: 16'h0800};
    hdr.ipv4 = '{ver_ihl: 8'h45, tos: 8'hb8, total_len: ip_len, ident: 16'h5555,
                 flags_frag: 16'h4000, ttl: 8'hba, protocol: 8'h11, checksum: 16'h0000,
                 src_ip: src_ip_i, dst_ip: ctx_i.dst_ip};
    hdr.ipv4.checksum = ip_csum(hdr.ipv4);
    hdr.udp  = '{src_port: 16'h6851, dst_port: 16'h12b7,
                 length: ip_len - 16'(`IPV4_HDR_BYTES), checksum: 16'h0000};
    hdr.bth  = '{opcode: req.kind, flags: 8'h30, pkey: 16'h666f, rsvd0: 8'h05,
                 dst_qp: req.qp, rsvd1: 8'h00, psn: req.psn};
    hdr.aeth = 32'h0000_0000;
  end

  // first wire byte into lane 0
  assign hdr_swap = {<<8{hdr}};

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      frame.valid <= 1'b0;
    end else begin
      frame.valid <= req.req;
    end
  end

  always_ff @(posedge core_clk) begin
    if (req.req) begin
      frame.hdr       <= hdr_swap;
      frame.hdr_len   <= hdr_len;
      frame.pay_len   <= pay_len;
      frame.pay_byte  <= pay_byte;
      frame.frame_len <= LW'(hdr_len) + pay_len + icrc_len;
    end
  end

endmodule

/* src/beat_serializer.sv */
`include "roce_gen_defs.svh"

module beat_serializer (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  frame_if.slave                  frame,
  input  logic                    tx_tready_i,
  output logic [`AXIS_W-1:0]      tx_tdata_o,
  output logic [`AXIS_BYTES-1:0]  tx_tkeep_o,
  output logic                    tx_tvalid_o,
  output logic                    tx_tlast_o
);

  localparam logic [`FRAME_LEN_W-1:0] BEAT_LEN = `AXIS_BYTES;

  logic [`BEAT_IDX_W-1:0]         beat_q;
  logic [`FRAME_LEN_W-1:0]        rem_q;
  logic [`AETH_HDR_BYTES*8-1:0]   hdr_q;
  logic [`HDR_LEN_W-1:0]          hdr_len_q;
  logic [`FRAME_LEN_W-1:0]        pay_end_q;
  logic [7:0]                     pay_byte_q;
  logic                           accept;

  assign accept     = tx_tvalid_o & tx_tready_i;
  assign tx_tlast_o = tx_tvalid_o & (rem_q <= BEAT_LEN);
  assign frame.done = accept & tx_tlast_o;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      tx_tvalid_o <= 1'b0;
      beat_q      <= '0;
      rem_q       <= '0;
    end else if (frame.valid) begin
      tx_tvalid_o <= 1'b1;
      beat_q      <= '0;
      rem_q       <= frame.frame_len;
    end else if (accept) begin
      tx_tvalid_o <= ~tx_tlast_o;
      beat_q      <= beat_q + 1'b1;
      rem_q       <= rem_q - BEAT_LEN;
    end
  end

  always_ff @(posedge core_clk) begin
    if (frame.valid) begin
      hdr_q      <= frame.hdr;
      hdr_len_q  <= frame.hdr_len;
      pay_end_q  <= `FRAME_LEN_W'(frame.hdr_len) + frame.pay_len;
      pay_byte_q <= frame.pay_byte;
    end
  end

  // header, then payload, then zero icrc
  for (genvar j = 0; j < `AXIS_BYTES; j++) begin : g_lane
    logic [`FRAME_LEN_W-1:0] pos;
    logic [7:0]              hdr_byte;

    assign pos = {beat_q, 6'(j)};
    if (j < `AETH_HDR_BYTES) begin : g_hdr
      assign hdr_byte = hdr_q[j*8 +: 8];
    end else begin : g_no_hdr
      assign hdr_byte = 8'h00;
    end
    assign tx_tdata_o[j*8 +: 8] = (pos < `FRAME_LEN_W'(hdr_len_q)) ? hdr_byte :
                                  (pos < pay_end_q)                ? pay_byte_q : 8'h00;
  end

  assign tx_tkeep_o = tx_tlast_o ? ~({`AXIS_BYTES{1'b1}} << rem_q) : {`AXIS_BYTES{1'b1}};

endmodule

/* src/roce_pkt_gen_top.sv */
`include "roce_gen_defs.svh"

module roce_pkt_gen_top (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  logic                    start_i,
  input  logic [47:0]             src_mac_i,
  input  logic [31:0]             src_ip_i,
  input  logic                    cfg_we_i,
  input  logic [`QP_IDX_W-1:0]    cfg_qp_i,
  input  logic [47:0]             cfg_mac_i,
  input  logic [31:0]             cfg_ip_i,
  input  logic [23:0]             cfg_psn_i,
  input  logic [`AXIS_W-1:0]      wqe_tdata_i,
  input  logic                    wqe_tvalid_i,
  input  logic                    tx_tready_i,
  output logic [`AXIS_W-1:0]      tx_tdata_o,
  output logic [`AXIS_BYTES-1:0]  tx_tkeep_o,
  output logic                    tx_tvalid_o,
  output logic                    tx_tlast_o,
  output logic                    post_rd_wqe_o,
  output logic                    post_wr_wqe_o,
  output logic                    send_done_o,
  output logic                    read_done_o,
  output logic                    write_done_o
);

  hdr_req_if i_hdr_req ();
  frame_if   i_frame ();

  gen_ctrl_pkg::qp_ctx_t  cfg_ctx;
  gen_ctrl_pkg::qp_ctx_t  rd_ctx;
  logic [`QP_IDX_W-1:0]   rd_idx;

  assign cfg_ctx = '{dst_mac: cfg_mac_i, dst_ip: cfg_ip_i, base_psn: cfg_psn_i};

  qp_context_table i_qp_context_table (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .we_i         (cfg_we_i),
    .wr_idx_i     (cfg_qp_i),
    .wr_ctx_i     (cfg_ctx),
    .rd_idx_i     (rd_idx),
    .rd_ctx_o     (rd_ctx)
  );

  pkt_sequencer i_pkt_sequencer (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .start_i       (start_i),
    .wqe_tdata_i   (wqe_tdata_i),
    .wqe_tvalid_i  (wqe_tvalid_i),
    .req           (i_hdr_req.master),
    .frame         (i_frame.monitor),
    .rd_base_psn_i (rd_ctx.base_psn),
    .rd_idx_o      (rd_idx),
    .post_rd_wqe_o (post_rd_wqe_o),
    .post_wr_wqe_o (post_wr_wqe_o),
    .send_done_o   (send_done_o),
    .read_done_o   (read_done_o),
    .write_done_o  (write_done_o)
  );

  roce_hdr_builder i_roce_hdr_builder (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .req          (i_hdr_req.slave),
    .src_mac_i    (src_mac_i),
    .src_ip_i     (src_ip_i),
    .ctx_i        (rd_ctx),
    .frame        (i_frame.master)
  );

  beat_serializer i_beat_serializer (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .frame        (i_frame.slave),
    .tx_tready_i  (tx_tready_i),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tkeep_o   (tx_tkeep_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o)
  );

endmodule

/* bench/clk_rst_gen.sv */
module clk_rst_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic core_clk,
  output logic core_aresetn
);

  initial begin
    core_clk = 1'b0;
    forever #(PERIOD / 2) core_clk = ~core_clk;
  end

  // release on a rising edge
  initial begin
    core_aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge core_clk);
    core_aresetn <= 1'b1;
  end

endmodule

/* bench/roce_pkt_gen_properties.sv */
`include "roce_gen_defs.svh"

module roce_pkt_gen_properties (
  input logic                    core_clk,
  input logic                    core_aresetn,
  input logic [`AXIS_W-1:0]      tx_tdata_i,
  input logic [`AXIS_BYTES-1:0]  tx_tkeep_i,
  input logic                    tx_tvalid_i,
  input logic                    tx_tlast_i,
  input logic                    tx_tready_i,
  input logic                    post_rd_wqe_i,
  input logic                    post_wr_wqe_i,
  input logic                    hdr_req_i,
  input logic                    frame_valid_i
);

  // stalled beat is held as is
  a_beat_hold: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_tvalid_i && !tx_tready_i |=> tx_tvalid_i && $stable(tx_tdata_i) &&
                                    $stable(tx_tkeep_i) && $stable(tx_tlast_i))
    else $error("tx beat changed while tready was low");

  a_post_rd_pulse: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_rd_wqe_i |=> !post_rd_wqe_i)
    else $error("read work request strobe longer than one cycle");

  a_post_wr_pulse: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_wr_wqe_i |=> !post_wr_wqe_i)
    else $error("write work request strobe longer than one cycle");

  // header request, frame strobe, first beat
  a_req_to_frame: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    hdr_req_i |=> frame_valid_i && !hdr_req_i)
    else $error("frame strobe did not follow the header request");

  a_frame_to_beat: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    frame_valid_i |=> tx_tvalid_i)
    else $error("first beat missing after frame strobe");

endmodule

/* bench/roce_pkt_gen_tb.sv */
`include "roce_gen_defs.svh"

module roce_pkt_gen_tb;

  localparam int TOTAL_FRAMES = `SEND_PKT_COUNT + `READ_PKT_COUNT + `WRITE_PKT_COUNT;
  localparam int CFG_ROWS     = `QP_COUNT;
  localparam int DESC_ROWS    = `READ_PKT_COUNT + `WRITE_PKT_COUNT;
  localparam int MAX_FRAME    = 512;
  localparam int WAIT_LIMIT   = 4000;
  localparam logic [47:0] SRC_MAC_ADDR = 48'h02_5e_10_20_30_40;
  localparam logic [31:0] SRC_IP_ADDR  = 32'hc0a8_0164;

  // one row is a queue pair setting or a descriptor answer
  // exp_op holds the opcode of the answering frame
  typedef struct packed {
    logic [23:0] qp;
    logic [47:0] mac;
    logic [31:0] ip;
    logic [23:0] psn;
    logic [7:0]  exp_op;
  } row_t;

  logic                    core_clk;
  logic                    core_aresetn;
  logic                    start;
  logic [47:0]             src_mac;
  logic [31:0]             src_ip;
  logic                    cfg_we;
  logic [`QP_IDX_W-1:0]    cfg_qp;
  logic [47:0]             cfg_mac;
  logic [31:0]             cfg_ip;
  logic [23:0]             cfg_psn;
  logic [`AXIS_W-1:0]      wqe_tdata;
  logic                    wqe_tvalid;
  logic                    tx_tready;
  logic [`AXIS_W-1:0]      tx_tdata;
  logic [`AXIS_BYTES-1:0]  tx_tkeep;
  logic                    tx_tvalid;
  logic                    tx_tlast;
  logic                    post_rd_wqe;
  logic                    post_wr_wqe;
  logic                    send_done;
  logic                    read_done;
  logic                    write_done;

  row_t        stim [CFG_ROWS + DESC_ROWS];
  logic [7:0]  exp_data [TOTAL_FRAMES][MAX_FRAME];
  int          exp_len [TOTAL_FRAMES];
  logic [47:0] ctx_mac [`QP_COUNT];
  logic [31:0] ctx_ip [`QP_COUNT];
  logic [23:0] ctx_psn [`QP_COUNT];
  int          frames_done = 0;

  clk_rst_gen #(.PERIOD(10), .RESET_CYCLES(5)) i_clk_rst_gen (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn)
  );

  roce_pkt_gen_top i_roce_pkt_gen_top (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .start_i       (start),
    .src_mac_i     (src_mac),
    .src_ip_i      (src_ip),
    .cfg_we_i      (cfg_we),
    .cfg_qp_i      (cfg_qp),
    .cfg_mac_i     (cfg_mac),
    .cfg_ip_i      (cfg_ip),
    .cfg_psn_i     (cfg_psn),
    .wqe_tdata_i   (wqe_tdata),
    .wqe_tvalid_i  (wqe_tvalid),
    .tx_tready_i   (tx_tready),
    .tx_tdata_o    (tx_tdata),
    .tx_tkeep_o    (tx_tkeep),
    .tx_tvalid_o   (tx_tvalid),
    .tx_tlast_o    (tx_tlast),
    .post_rd_wqe_o (post_rd_wqe),
    .post_wr_wqe_o (post_wr_wqe),
    .send_done_o   (send_done),
    .read_done_o   (read_done),
    .write_done_o  (write_done)
  );

  bind roce_pkt_gen_top roce_pkt_gen_properties i_roce_pkt_gen_properties (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .tx_tdata_i    (tx_tdata_o),
    .tx_tkeep_i    (tx_tkeep_o),
    .tx_tvalid_i   (tx_tvalid_o),
    .tx_tlast_i    (tx_tlast_o),
    .tx_tready_i   (tx_tready_i),
    .post_rd_wqe_i (post_rd_wqe_o),
    .post_wr_wqe_i (post_wr_wqe_o),
    .hdr_req_i     (i_hdr_req.req),
    .frame_valid_i (i_frame.valid)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      stop_with_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, act, exp));
    end
  endtask

  task automatic fill_table();
    stim[0]  = '{24'h000000, 48'h02_00_00_00_00_a0, 32'hc0a8_0a01, 24'hfffffc, 8'h00};
    stim[1]  = '{24'h000001, 48'h02_00_00_00_00_b1, 32'hc0a8_0a02, 24'h001000, 8'h00};
    stim[2]  = '{24'h000002, 48'h02_00_00_00_00_c2, 32'h0a01_0203, 24'h7ffffe, 8'h00};
    stim[3]  = '{24'h000003, 48'h02_00_00_00_00_d3, 32'hac10_fe01, 24'h000000, 8'h00};
    // read responses
    stim[4]  = '{24'h000001, 48'h0, 32'h0, 24'h000100, 8'h10};
    stim[5]  = '{24'h0a0b02, 48'h0, 32'h0, 24'h123456, 8'h10};
    stim[6]  = '{24'h000003, 48'h0, 32'h0, 24'hfffffe, 8'h10};
    stim[7]  = '{24'hc0ff00, 48'h0, 32'h0, 24'h000000, 8'h10};
    stim[8]  = '{24'h000102, 48'h0, 32'h0, 24'h00abcd, 8'h10};
    stim[9]  = '{24'h7f0003, 48'h0, 32'h0, 24'h800000, 8'h10};
    stim[10] = '{24'h000011, 48'h0, 32'h0, 24'h0f0f0f, 8'h10};
    stim[11] = '{24'hffffff, 48'h0, 32'h0, 24'h654321, 8'h10};
    // acks
    stim[12] = '{24'h000000, 48'h0, 32'h0, 24'h000010, 8'h11};
    stim[13] = '{24'h000005, 48'h0, 32'h0, 24'h111111, 8'h11};
    stim[14] = '{24'h00020a, 48'h0, 32'h0, 24'h222222, 8'h11};
    stim[15] = '{24'h30000f, 48'h0, 32'h0, 24'hfffff0, 8'h11};
    stim[16] = '{24'h000001, 48'h0, 32'h0, 24'h000001, 8'h11};
    stim[17] = '{24'h123456, 48'h0, 32'h0, 24'habcdef, 8'h11};
    stim[18] = '{24'h000003, 48'h0, 32'h0, 24'h7fffff, 8'h11};
    stim[19] = '{24'hfedcba, 48'h0, 32'h0, 24'h000002, 8'h11};
  endtask

  // wire bytes of one frame with the first byte at index 0
  task automatic build_expected(input int f, input logic [7:0] op, input logic [23:0] qp,
                                input logic [23:0] psn, input logic [7:0] seq);
    int           hdr_len;
    int           pay_len;
    int           icrc_len;
    logic [15:0]  ip_len;
    logic [7:0]   pay;
    logic [31:0]  sum;
    logic [463:0] hv;
    logic [1:0]   idx;
    idx      = qp[1:0];
    hdr_len  = 58;
    pay_len  = 0;
    icrc_len = 0;
    ip_len   = 16'h0030;
    pay      = 8'h00;
    if (op == 8'h04) begin
      hdr_len = 54;
      pay_len = 80;
      ip_len  = 16'h007c;
      pay     = seq + 8'd1;
    end else if (op == 8'h10) begin
      pay_len  = 256;
      icrc_len = 4;
      ip_len   = 16'h0130;
      pay      = {4'h1, seq[3:0] + 4'h1};
    end
    hv = {ctx_mac[idx], SRC_MAC_ADDR, 16'h0800,
          8'h45, 8'hb8, ip_len, 16'h5555, 16'h4000, 8'hba, 8'h11, 16'h0000,
          SRC_IP_ADDR, ctx_ip[idx],
          16'h6851, 16'h12b7, ip_len - 16'd20, 16'h0000,
          op, 8'h30, 16'h666f, 8'h05, qp, 8'h00, psn, 32'h0000_0000};
    // ipv4 header spans bytes 14 to 33
    sum = 0;
    for (int i = 14; i < 34; i += 2) begin
      sum = sum + 32'(hv[(58-i)*8-1 -: 16]);
    end
    while (sum[31:16] != 0) begin
      sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    end
    hv[(58-24)*8-1 -: 16] = ~sum[15:0];
    exp_len[f] = hdr_len + pay_len + icrc_len;
    for (int i = 0; i < exp_len[f]; i++) begin
      if (i < hdr_len) begin
        exp_data[f][i] = hv[(58-i)*8-1 -: 8];
      end else if (i < hdr_len + pay_len) begin
        exp_data[f][i] = pay;
      end else begin
        exp_data[f][i] = 8'h00;
      end
    end
  endtask

  task automatic prepare_expected();
    row_t r;
    for (int i = 0; i < CFG_ROWS; i++) begin
      ctx_mac[stim[i].qp[1:0]] = stim[i].mac;
      ctx_ip[stim[i].qp[1:0]]  = stim[i].ip;
      ctx_psn[stim[i].qp[1:0]] = stim[i].psn;
    end
    // send k goes to qp k mod 4
    for (int k = 0; k < `SEND_PKT_COUNT; k++) begin
      build_expected(k, 8'h04, 24'(k % `QP_COUNT), ctx_psn[k % `QP_COUNT] + 24'(k), 8'(k));
    end
    for (int i = 0; i < DESC_ROWS; i++) begin
      r = stim[CFG_ROWS + i];
      build_expected(`SEND_PKT_COUNT + i, r.exp_op, r.qp, r.psn, 8'(i % `READ_PKT_COUNT));
    end
  endtask

  initial begin : ready_gen
    tx_tready <= 1'b0;
    void'($urandom(50375));
    forever begin
      @(posedge core_clk);
      tx_tready <= ($urandom % 4) != 0;
    end
  end

  initial begin : monitor
    int          beat;
    int          rem;
    logic [63:0] keep_exp;
    beat = 0;
    forever begin
      @(negedge core_clk);
      if (core_aresetn && ((read_done && !send_done) || (write_done && !read_done))) begin
        stop_with_failure("a done flag rose before the flag of the earlier phase");
      end
      if (core_aresetn && tx_tvalid && tx_tready) begin
        if (frames_done >= TOTAL_FRAMES) begin
          stop_with_failure("a frame arrived after the last expected frame");
        end
        rem      = exp_len[frames_done] - beat * `AXIS_BYTES;
        keep_exp = (rem >= `AXIS_BYTES) ? '1 : ((64'd1 << rem) - 64'd1);
        check("tx_tkeep_o", tx_tkeep, keep_exp);
        check("tx_tlast_o", tx_tlast, rem <= `AXIS_BYTES);
        for (int j = 0; j < `AXIS_BYTES && j < rem; j++) begin
          check($sformatf("tx_tdata_o frame %0d byte %0d", frames_done, beat * 64 + j),
                tx_tdata[j*8 +: 8], exp_data[frames_done][beat * 64 + j]);
        end
        if (tx_tlast) begin
          check("send_done_o", send_done, frames_done >= `SEND_PKT_COUNT);
          check("read_done_o", read_done, frames_done >= `SEND_PKT_COUNT + `READ_PKT_COUNT);
          check("write_done_o", write_done, 1'b0);
          frames_done++;
          beat = 0;
        end else begin
          beat++;
        end
      end
    end
  end

  initial begin : driver
    int                 wait_cnt;
    logic [`AXIS_W-1:0] desc;
    start      <= 1'b0;
    src_mac    <= SRC_MAC_ADDR;
    src_ip     <= SRC_IP_ADDR;
    cfg_we     <= 1'b0;
    cfg_qp     <= '0;
    cfg_mac    <= '0;
    cfg_ip     <= '0;
    cfg_psn    <= '0;
    wqe_tdata  <= '0;
    wqe_tvalid <= 1'b0;
    fill_table();
    prepare_expected();

    wait_cnt = 0;
    while (core_aresetn !== 1'b1) begin
      @(negedge core_clk);
      wait_cnt++;
      if (wait_cnt > 100) begin
        stop_with_failure("reset was never released");
      end
    end
    @(negedge core_clk);
    check("tx_tvalid_o", tx_tvalid, 1'b0);
    check("tx_tlast_o", tx_tlast, 1'b0);
    check("post_rd_wqe_o", post_rd_wqe, 1'b0);
    check("post_wr_wqe_o", post_wr_wqe, 1'b0);
    check("send_done_o", send_done, 1'b0);
    check("read_done_o", read_done, 1'b0);
    check("write_done_o", write_done, 1'b0);

    for (int row = 0; row < CFG_ROWS; row++) begin
      @(posedge core_clk);
      cfg_we  <= 1'b1;
      cfg_qp  <= stim[row].qp[`QP_IDX_W-1:0];
      cfg_mac <= stim[row].mac;
      cfg_ip  <= stim[row].ip;
      cfg_psn <= stim[row].psn;
    end
    @(posedge core_clk);
    cfg_we <= 1'b0;
    start  <= 1'b1;
    @(posedge core_clk);
    start <= 1'b0;

    // one descriptor per posted work request
    for (int row = CFG_ROWS; row < CFG_ROWS + DESC_ROWS; row++) begin
      wait_cnt = 0;
      do begin
        @(negedge core_clk);
        wait_cnt++;
        if (wait_cnt > WAIT_LIMIT) begin
          stop_with_failure("no work request was posted in time");
        end
      end while (!(post_rd_wqe || post_wr_wqe));
      check("post_rd_wqe_o", post_rd_wqe, stim[row].exp_op == 8'h10);
      check("post_wr_wqe_o", post_wr_wqe, stim[row].exp_op == 8'h11);
      if (frames_done != `SEND_PKT_COUNT + row - CFG_ROWS) begin
        stop_with_failure("work request posted while the previous frame was unfinished");
      end
      desc = {8{64'h0123_4567_89ab_cdef}};
      desc[`WQE_QP_BYTE*8 +: 8]      = stim[row].qp[23:16];
      desc[(`WQE_QP_BYTE+1)*8 +: 8]  = stim[row].qp[15:8];
      desc[(`WQE_QP_BYTE+2)*8 +: 8]  = stim[row].qp[7:0];
      desc[`WQE_PSN_BYTE*8 +: 8]     = stim[row].psn[23:16];
      desc[(`WQE_PSN_BYTE+1)*8 +: 8] = stim[row].psn[15:8];
      desc[(`WQE_PSN_BYTE+2)*8 +: 8] = stim[row].psn[7:0];
      @(posedge core_clk);
      wqe_tdata  <= desc;
      wqe_tvalid <= 1'b1;
      @(posedge core_clk);
      wqe_tvalid <= 1'b0;
    end

    wait_cnt = 0;
    do begin
      @(negedge core_clk);
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) begin
        stop_with_failure("the write phase did not finish in time");
      end
    end while (!write_done);
    check("send_done_o", send_done, 1'b1);
    check("read_done_o", read_done, 1'b1);

    if (frames_done == TOTAL_FRAMES) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_with_failure($sformatf("only %0d of %0d frames arrived", frames_done,
                                  TOTAL_FRAMES));
    end
  end

endmodule

/* roce_pkt_gen_top.f */
+incdir+src
src/gen_ctrl_pkg.sv
src/roce_hdr_pkg.sv
src/gen_ifs.sv
src/qp_context_table.sv
src/pkt_sequencer.sv
src/roce_hdr_builder.sv
src/beat_serializer.sv
src/roce_pkt_gen_top.sv
bench/clk_rst_gen.sv
bench/roce_pkt_gen_properties.sv
bench/roce_pkt_gen_tb.sv

/* Bender.yml */
package:
  name: roce_pkt_gen

sources:
  - include_dirs:
      - src
    files:
      - src/gen_ctrl_pkg.sv
      - src/roce_hdr_pkg.sv
      - src/gen_ifs.sv
      - src/qp_context_table.sv
      - src/pkt_sequencer.sv
      - src/roce_hdr_builder.sv
      - src/beat_serializer.sv
      - src/roce_pkt_gen_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/clk_rst_gen.sv
      - bench/roce_pkt_gen_properties.sv
      - bench/roce_pkt_gen_tb.sv
